// ==== hdl/ordr_pkg.sv ====
`default_nettype none

package ordr_pkg;

  // table and data sizes
  localparam int ENTRY_COUNT = 16;
  localparam int IDX_W       = $clog2(ENTRY_COUNT);
  localparam int DATA_W      = 64;

  // output credits held after reset
  localparam int OUT_CREDITS = 4;
  localparam int CRED_W      = $clog2(OUT_CREDITS + 1);

  // memory address field widths
  localparam int CH_W   = 2;
  localparam int BANK_W = 4;
  localparam int ROW_W  = 14;
  localparam int COL_W  = 6;

  typedef enum logic [1:0] {
    RD_MEM = 2'd0,
    RD_SBK = 2'd1,
    RD_ACC = 2'd2,
    RD_ACT = 2'd3
  } rd_kind_e;

  typedef enum logic {
    DEST_BUS  = 1'b0,
    DEST_PGEN = 1'b1
  } dest_e;

  typedef struct packed {
    logic [CH_W-1:0]   ch;
    logic [BANK_W-1:0] bank;
    logic [ROW_W-1:0]  row;
    logic [COL_W-1:0]  col;
  } mem_addr_t;

  typedef struct packed {
    mem_addr_t addr;
    rd_kind_e  kind;
  } rd_req_t;

  typedef struct packed {
    mem_addr_t         addr;
    logic [DATA_W-1:0] data;
  } rd_resp_t;

  typedef struct packed {
    dest_e             dest;
    mem_addr_t         addr;
    logic [DATA_W-1:0] data;
  } out_pkt_t;

  // one slot of the outstanding read table
  typedef struct packed {
    logic      occupied;
    mem_addr_t addr;
    rd_kind_e  kind;
  } entry_t;

  // plain memory reads return to the bus bridge, all others to the packet generator
  function automatic dest_e dest_of(input rd_kind_e kind);
    return (kind == RD_MEM) ? DEST_BUS : DEST_PGEN;
  endfunction

endpackage

`default_nettype wire

// ==== hdl/ordr_tag_table.sv ====
`timescale 1ns/10ps
`default_nettype none

module ordr_tag_table (
  input  logic                                              clk,
  input  logic                                              rst,
  // request side
  input  logic                                              i_req_valid,
  input  ordr_pkg::rd_req_t                                 i_req,
  // head release from the data store
  input  logic                                              i_release,
  // table view for search and release
  output ordr_pkg::entry_t [ordr_pkg::ENTRY_COUNT-1:0]      o_entries,
  output logic [ordr_pkg::IDX_W-1:0]                        o_head_idx,
  output logic                                              o_req_credit
);

  import ordr_pkg::*;

  // head is the oldest outstanding read, tail the next free slot
  logic [IDX_W-1:0]       head_idx;
  logic [IDX_W-1:0]       tail_idx;
  logic [ENTRY_COUNT-1:0] occupied;

  // address and kind of each entry
  mem_addr_t              addr_mem [ENTRY_COUNT];
  rd_kind_e               kind_mem [ENTRY_COUNT];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      head_idx     <= '0;
      tail_idx     <= '0;
      occupied     <= '0;
      o_req_credit <= 1'b0;
    end else begin
      // one credit back per released entry
      o_req_credit <= i_release;

      if (i_req_valid) begin
        occupied[tail_idx] <= 1'b1;
        tail_idx           <= tail_idx + IDX_W'(1);
      end

      // release and allocate never hit the same slot, the requester
      // holds no credit while the table is full
      if (i_release) begin
        occupied[head_idx] <= 1'b0;
        head_idx           <= head_idx + IDX_W'(1);
      end
    end
  end

  // entry payload, written at the tail
  always_ff @(posedge clk) begin
    if (i_req_valid) begin
      addr_mem[tail_idx] <= i_req.addr;
      kind_mem[tail_idx] <= i_req.kind;
    end
  end

  // pack the table for the other blocks
  always_comb begin
    for (int i = 0; i < ENTRY_COUNT; i++) begin
      o_entries[i].occupied = occupied[i];
      o_entries[i].addr     = addr_mem[i];
      o_entries[i].kind     = kind_mem[i];
    end
  end

  assign o_head_idx = head_idx;

endmodule

`default_nettype wire

// ==== hdl/ordr_match.sv ====
`timescale 1ns/10ps
`default_nettype none

module ordr_match (
  // table state
  input  ordr_pkg::entry_t [ordr_pkg::ENTRY_COUNT-1:0]      i_entries,
  input  logic [ordr_pkg::ENTRY_COUNT-1:0]                  i_filled,
  input  logic [ordr_pkg::IDX_W-1:0]                        i_head_idx,
  // incoming response
  input  logic                                              i_resp_valid,
  input  ordr_pkg::mem_addr_t                               i_resp_addr,
  // search result
  output logic                                              o_hit,
  output logic [ordr_pkg::IDX_W-1:0]                        o_hit_idx
);

  import ordr_pkg::*;

  logic [ENTRY_COUNT-1:0] cand;
  logic                   found;
  logic [IDX_W-1:0]       found_idx;

  // entries still waiting for data at this address
  always_comb begin
    for (int i = 0; i < ENTRY_COUNT; i++) begin
      cand[i] = i_entries[i].occupied && !i_filled[i] &&
                (i_entries[i].addr == i_resp_addr);
    end
  end

  // walk from the head so the oldest candidate wins
  always_comb begin
    logic [IDX_W-1:0] idx;
    idx       = i_head_idx;
    found     = 1'b0;
    found_idx = i_head_idx;
    for (int i = 0; i < ENTRY_COUNT; i++) begin
      idx = i_head_idx + IDX_W'(i);
      if (!found && cand[idx]) begin
        found     = 1'b1;
        found_idx = idx;
      end
    end
  end

  assign o_hit     = i_resp_valid && found;
  assign o_hit_idx = found_idx;

endmodule

`default_nettype wire

// ==== hdl/ordr_data_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module ordr_data_store (
  input  logic                                              clk,
  input  logic                                              rst,
  // table state
  input  ordr_pkg::entry_t [ordr_pkg::ENTRY_COUNT-1:0]      i_entries,
  input  logic [ordr_pkg::IDX_W-1:0]                        i_head_idx,
  // match result and response data
  input  logic                                              i_hit,
  input  logic [ordr_pkg::IDX_W-1:0]                        i_hit_idx,
  input  logic [ordr_pkg::DATA_W-1:0]                       i_resp_data,
  // output credit return
  input  logic                                              i_out_credit,
  output logic [ordr_pkg::ENTRY_COUNT-1:0]                  o_filled,
  output logic                                              o_release,
  output logic                                              o_out_valid,
  output ordr_pkg::out_pkt_t                                o_out
);

  import ordr_pkg::*;

  logic [DATA_W-1:0] data_mem [ENTRY_COUNT];
  logic [CRED_W-1:0] credit_cnt;
  entry_t            head_entry;

  assign head_entry = i_entries[i_head_idx];

  // oldest entry has its data and the consumer has room
  assign o_release = o_filled[i_head_idx] && (credit_cnt != '0);

  // output credits, one spent per release
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      credit_cnt <= CRED_W'(OUT_CREDITS);
    end else begin
      case ({i_out_credit, o_release})
        2'b10:   credit_cnt <= credit_cnt + CRED_W'(1);
        2'b01:   credit_cnt <= credit_cnt - CRED_W'(1);
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // filled flags and output strobe
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_filled    <= '0;
      o_out_valid <= 1'b0;
    end else begin
      o_out_valid <= o_release;
      if (i_hit) begin
        o_filled[i_hit_idx] <= 1'b1;
      end
      // a hit never targets a filled head, so these cannot collide
      if (o_release) begin
        o_filled[i_head_idx] <= 1'b0;
      end
    end
  end

  // data slots and outgoing packet
  always_ff @(posedge clk) begin
    if (i_hit) begin
      data_mem[i_hit_idx] <= i_resp_data;
    end
    if (o_release) begin
      o_out.dest <= dest_of(head_entry.kind);
      o_out.addr <= head_entry.addr;
      o_out.data <= data_mem[i_head_idx];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/ordr_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module ordr_engine (
  input  logic                 clk,
  input  logic                 rst,
  // read requests in program order
  input  logic                 i_req_valid,
  input  ordr_pkg::rd_req_t    i_req,
  output logic                 o_req_credit,
  // read responses in any order
  input  logic                 i_resp_valid,
  input  ordr_pkg::rd_resp_t   i_resp,
  // in-order output stream
  output logic                 o_out_valid,
  output ordr_pkg::out_pkt_t   o_out,
  input  logic                 i_out_credit
);

  import ordr_pkg::*;

  entry_t [ENTRY_COUNT-1:0] entries;
  logic [IDX_W-1:0]         head_idx;
  logic [ENTRY_COUNT-1:0]   filled;
  logic                     release_head;
  logic                     hit;
  logic [IDX_W-1:0]         hit_idx;

  ordr_tag_table u_tag_table (
    .clk          (clk),
    .rst          (rst),
    .i_req_valid  (i_req_valid),
    .i_req        (i_req),
    .i_release    (release_head),
    .o_entries    (entries),
    .o_head_idx   (head_idx),
    .o_req_credit (o_req_credit)
  );

  ordr_match u_match (
    .i_entries    (entries),
    .i_filled     (filled),
    .i_head_idx   (head_idx),
    .i_resp_valid (i_resp_valid),
    .i_resp_addr  (i_resp.addr),
    .o_hit        (hit),
    .o_hit_idx    (hit_idx)
  );

  ordr_data_store u_data_store (
    .clk          (clk),
    .rst          (rst),
    .i_entries    (entries),
    .i_head_idx   (head_idx),
    .i_hit        (hit),
    .i_hit_idx    (hit_idx),
    .i_resp_data  (i_resp.data),
    .i_out_credit (i_out_credit),
    .o_filled     (filled),
    .o_release    (release_head),
    .o_out_valid  (o_out_valid),
    .o_out        (o_out)
  );

endmodule

`default_nettype wire

// ==== bench/ordr_engine_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module ordr_engine_checker (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                i_req_valid,
  input  logic                                i_resp_valid,
  input  logic                                o_out_valid,
  input  logic                                i_out_credit,
  input  logic                                hit,
  input  logic [ordr_pkg::ENTRY_COUNT-1:0]    occupied,
  input  logic [ordr_pkg::CRED_W-1:0]         credit_cnt
);

  import ordr_pkg::*;

  logic cred_d;
  int   avail;

  // credits the engine holds, seen from its ports
  // a returned credit counts from the edge after it is sampled
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cred_d <= 1'b0;
      avail  <= OUT_CREDITS;
    end else begin
      cred_d <= i_out_credit;
      avail  <= avail + int'(cred_d) - int'(o_out_valid);
    end
  end

  // requester must hold a credit, so the table has room
  a_no_req_when_full: assert property (@(posedge clk) disable iff (rst)
    i_req_valid |-> !(&occupied))
    else $error("request while table full");

  // every output needs a credit that was already back
  a_no_out_without_credit: assert property (@(posedge clk) disable iff (rst)
    o_out_valid |-> (avail > 0))
    else $error("output sent with zero credits");

  a_credit_bound: assert property (@(posedge clk) disable iff (rst)
    credit_cnt <= CRED_W'(OUT_CREDITS))
    else $error("output credit count overflow");

  a_resp_hits: assert property (@(posedge clk) disable iff (rst)
    i_resp_valid |-> hit)
    else $error("response without pending entry");

endmodule

bind ordr_engine ordr_engine_checker chk0 (
  .clk          (clk),
  .rst          (rst),
  .i_req_valid  (i_req_valid),
  .i_resp_valid (i_resp_valid),
  .o_out_valid  (o_out_valid),
  .i_out_credit (i_out_credit),
  .hit          (hit),
  .occupied     (u_tag_table.occupied),
  .credit_cnt   (u_data_store.credit_cnt)
);

`default_nettype wire

// ==== bench/ordr_engine_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module ordr_engine_tb;

  import ordr_pkg::*;

  logic      clk;
  logic      rst;
  logic      i_req_valid;
  rd_req_t   i_req;
  logic      o_req_credit;
  logic      i_resp_valid;
  rd_resp_t  i_resp;
  logic      o_out_valid;
  out_pkt_t  o_out;
  logic      i_out_credit;

  // model of issued requests, in request order
  mem_addr_t         req_addr [256];
  rd_kind_e          req_kind [256];
  logic [DATA_W-1:0] req_data [256];
  bit                got      [256];
  int n_req, n_out, credits_back, credit_ret, errors, test_err;
  bit auto_credit;
  logic [15:0] lfsr;
  logic [5:0]  col_cnt;

  ordr_engine dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // taps 16,14,13,11
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      v = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic mem_addr_t new_addr();
    mem_addr_t a;
    a.ch   = CH_W'(rand_bits(CH_W));
    a.bank = BANK_W'(rand_bits(BANK_W));
    a.row  = ROW_W'(rand_bits(ROW_W));
    a.col  = col_cnt;
    col_cnt++;
    return a;
  endfunction

  // expected packet for the k-th request
  function automatic out_pkt_t expected_out(input int k);
    out_pkt_t p;
    case (req_kind[k])
      RD_MEM:                 p.dest = DEST_BUS;
      RD_SBK, RD_ACC, RD_ACT: p.dest = DEST_PGEN;
    endcase
    p.addr = req_addr[k];
    p.data = req_data[k];
    return p;
  endfunction

  task automatic abort(input string msg);
    $display("%s at %0t", msg, $time);
    $display("Testbench failed");
    $finish;
  endtask

  task automatic send_req(input mem_addr_t a, input rd_kind_e k);
    int t;
    t = 0;
    while (n_req - credits_back >= ENTRY_COUNT) begin
      @(negedge clk);
      t++;
      if (t > 300) abort("timeout waiting for a request credit");
    end
    i_req_valid = 1'b1;
    i_req = '{addr: a, kind: k};
    req_addr[n_req] = a;
    req_kind[n_req] = k;
    got[n_req] = 1'b0;
    n_req++;
    @(negedge clk);
    i_req_valid = 1'b0;
  endtask

  // the oldest pending request with this address takes the data
  task automatic send_resp(input mem_addr_t a, input logic [DATA_W-1:0] d);
    int k;
    k = -1;
    for (int j = n_req - 1; j >= 0; j--) begin
      if (!got[j] && req_addr[j] == a) k = j;
    end
    if (k < 0) abort("response address has no pending request");
    got[k] = 1'b1;
    req_data[k] = d;
    i_resp_valid = 1'b1;
    i_resp = '{addr: a, data: d};
    @(negedge clk);
    i_resp_valid = 1'b0;
  endtask

  task automatic wait_outputs(input int target, input int limit, output bit ok);
    int t;
    t = 0;
    while (n_out < target && t < limit) begin
      @(negedge clk);
      t++;
    end
    ok = (n_out >= target);
  endtask

  task automatic wait_credits_returned();
    int t;
    t = 0;
    while (credit_ret < n_out) begin
      @(negedge clk);
      t++;
      if (t > 50) abort("timeout waiting for output credits to return");
    end
  endtask

  task automatic end_test(input string name);
    $display("test %s done, %0d errors", name, errors - test_err);
    test_err = errors;
  endtask

  // compare every output in request order
  always begin
    @(posedge clk);
    #10;
    if (!rst && o_out_valid) begin
      if (o_out !== expected_out(n_out)) begin
        $display("mismatch at %0t: output %0d got %h expected %h",
                 $time, n_out, o_out, expected_out(n_out));
        errors++;
      end
      n_out++;
    end
    if (!rst && o_req_credit) credits_back++;
  end

  // one output credit back per cycle while enabled
  always @(negedge clk) begin
    i_out_credit = 1'b0;
    if (auto_credit && credit_ret < n_out) begin
      i_out_credit = 1'b1;
      credit_ret++;
    end
  end

  initial begin
    int base;
    int ord [8];
    int tmp, j;
    bit ok;
    mem_addr_t a;
    rst = 1'b1;
    i_req_valid = 1'b0;
    i_req = '0;
    i_resp_valid = 1'b0;
    i_resp = '0;
    i_out_credit = 1'b0;
    n_req = 0;
    n_out = 0;
    credits_back = 0;
    credit_ret = 0;
    errors = 0;
    test_err = 0;
    auto_credit = 1'b1;
    lfsr = 16'd62;
    col_cnt = '0;
    repeat (5) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    // in-order responses
    base = n_req;
    for (int i = 0; i < 8; i++) send_req(new_addr(), rd_kind_e'(rand_bits(2)));
    for (int i = 0; i < 8; i++) send_resp(req_addr[base + i], rand_bits(DATA_W));
    wait_outputs(n_req, 200, ok);
    if (!ok) abort("timeout waiting for in-order outputs");
    end_test("in_order");

    // reversed then shuffled responses
    for (int r = 0; r < 2; r++) begin
      base = n_req;
      for (int i = 0; i < 8; i++) send_req(new_addr(), rd_kind_e'(rand_bits(2)));
      for (int i = 0; i < 8; i++) ord[i] = (r == 0) ? 7 - i : i;
      if (r == 1) begin
        for (int i = 7; i > 0; i--) begin
          j = int'(rand_bits(8)) % (i + 1);
          tmp = ord[i];
          ord[i] = ord[j];
          ord[j] = tmp;
        end
      end
      for (int i = 0; i < 8; i++) send_resp(req_addr[base + ord[i]], rand_bits(DATA_W));
      wait_outputs(n_req, 200, ok);
      if (!ok) abort("timeout waiting for reordered outputs");
    end
    end_test("out_of_order");

    // same address three times, oldest matched first
    a = new_addr();
    send_req(a, RD_SBK);
    send_req(a, RD_ACC);
    send_req(a, RD_MEM);
    for (int i = 0; i < 3; i++) send_resp(a, rand_bits(DATA_W));
    wait_outputs(n_req, 200, ok);
    if (!ok) abort("timeout waiting for same-address outputs");
    end_test("same_addr");

    // every read kind and its destination
    base = n_req;
    for (int i = 0; i < 4; i++) send_req(new_addr(), rd_kind_e'(i));
    for (int i = 3; i >= 0; i--) send_resp(req_addr[base + i], rand_bits(DATA_W));
    wait_outputs(n_req, 200, ok);
    if (!ok) abort("timeout waiting for read-kind outputs");
    end_test("dest");

    // output credits held back, engine starts with all of them
    wait_credits_returned();
    auto_credit = 1'b0;
    base = n_req;
    for (int i = 0; i < 10; i++) send_req(new_addr(), rd_kind_e'(rand_bits(2)));
    for (int i = 0; i < 10; i++) send_resp(req_addr[base + i], rand_bits(DATA_W));
    wait_outputs(n_req, 60, ok);
    if (ok || n_out != base + OUT_CREDITS) begin
      $display("mismatch at %0t: %0d outputs without credit, expected %0d",
               $time, n_out - base, OUT_CREDITS);
      errors++;
    end
    auto_credit = 1'b1;
    wait_outputs(n_req, 200, ok);
    if (!ok) abort("timeout waiting for outputs after credit return");
    end_test("backpressure");

    // full table, then one new request per returned credit
    base = n_req;
    tmp = credits_back;
    for (int i = 0; i < ENTRY_COUNT; i++) send_req(new_addr(), rd_kind_e'(rand_bits(2)));
    for (int i = 0; i < 4; i++) begin
      send_resp(req_addr[base + i], rand_bits(DATA_W));
      send_req(new_addr(), rd_kind_e'(rand_bits(2)));
    end
    for (int i = 4; i < ENTRY_COUNT + 4; i++) send_resp(req_addr[base + i], rand_bits(DATA_W));
    wait_outputs(n_req, 300, ok);
    if (!ok) abort("timeout waiting for full-table outputs");
    if (credits_back - tmp != n_out - base) begin
      $display("mismatch at %0t: %0d request credits for %0d outputs",
               $time, credits_back - tmp, n_out - base);
      errors++;
    end
    end_test("full_table");

    $display("%0d requests, %0d outputs, %0d errors", n_req, n_out, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
hdl/ordr_pkg.sv
hdl/ordr_tag_table.sv
hdl/ordr_match.sv
hdl/ordr_data_store.sv
hdl/ordr_engine.sv
bench/ordr_engine_checker.sv
bench/ordr_engine_tb.sv

// ==== Makefile ====
TOP = ordr_engine_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f -o sim_tb
	@out=$$(./obj_dir/sim_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir
